// ==== verilog/axi_pkg.sv ====
package axi_pkg;

	// request fields
	typedef logic [31:0] addr_t;
	typedef logic [7:0]  id_t;
	typedef logic [7:0]  len_t;
	typedef logic [2:0]  size_t;
	typedef logic [1:0]  burst_t;

	// burst kinds
	localparam burst_t BURST_FIXED = 2'b00;
	localparam burst_t BURST_INCR  = 2'b01;
	localparam burst_t BURST_WRAP  = 2'b10;

	// data path
	localparam int DATA_W = 64;

	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [DATA_W/8-1:0] strb_t;

endpackage

// ==== verilog/beat_pkg.sv ====
package beat_pkg;

	// last flag on top of the id
	typedef logic [$bits(axi_pkg::id_t):0] tag_t;

	// packed beat is {addr, data, write, tag, size}
	localparam int beat_w = $bits(axi_pkg::addr_t)
		+ $bits(axi_pkg::data_t)
		+ 1
		+ $bits(tag_t)
		+ $bits(axi_pkg::size_t);

	typedef logic [beat_w-1:0] beat_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BURST,
		READ_START,
		READ_BURST
	} seq_state_t;

endpackage

// ==== verilog/burst_sequencer.sv ====
`timescale 1ns/100ps

module burst_sequencer (
	input  logic              aclk,
	input  logic              aresetn,
	input  axi_pkg::id_t      awid,
	input  axi_pkg::addr_t    awaddr,
	input  axi_pkg::len_t     awlen,
	input  axi_pkg::size_t    awsize,
	input  axi_pkg::burst_t   awburst,
	input  logic              awvalid,
	output logic              awready,
	input  axi_pkg::data_t    wdata,
	input  axi_pkg::strb_t    wstrb,
	input  logic              wlast,
	input  logic              wvalid,
	output logic              wready,
	input  axi_pkg::id_t      arid,
	input  axi_pkg::addr_t    araddr,
	input  axi_pkg::len_t     arlen,
	input  axi_pkg::size_t    arsize,
	input  axi_pkg::burst_t   arburst,
	input  logic              arvalid,
	output logic              arready,
	input  logic              queue_full,
	output logic              beat_push,
	output beat_pkg::beat_t   push_beat
);

	beat_pkg::seq_state_t state;

	// request being expanded for either direction
	axi_pkg::id_t    req_id;
	axi_pkg::addr_t  req_addr;
	axi_pkg::len_t   req_len;
	axi_pkg::size_t  req_size;
	axi_pkg::burst_t req_burst;

	axi_pkg::len_t   beat_cnt;

	logic            in_read;
	logic            aw_take;
	logic            ar_take;
	logic            last_beat;
	axi_pkg::addr_t  beat_addr;
	axi_pkg::data_t  wdata_masked;
	axi_pkg::data_t  beat_data;
	beat_pkg::tag_t  beat_tag;

	assign in_read = (state == beat_pkg::READ_START) || (state == beat_pkg::READ_BURST);

	// write wins in idle
	assign awready = (state == beat_pkg::IDLE) && !queue_full;
	assign arready = (state == beat_pkg::IDLE) && arvalid && !awvalid && !queue_full;
	assign wready  = (state == beat_pkg::WRITE_BURST) && !queue_full;

	assign aw_take = awvalid && awready;
	assign ar_take = arvalid && arready;

	assign beat_push = (wvalid && wready) || (in_read && !queue_full);

	// zero the bytes without a strobe
	always_comb begin
		for (int i = 0; i < axi_pkg::DATA_W / 8; i++) begin
			wdata_masked[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : 8'h00;
		end
	end

	// fixed bursts stay on the start address
	assign beat_addr = (req_burst == axi_pkg::BURST_FIXED) ? req_addr :
		req_addr + (axi_pkg::addr_t'(beat_cnt) << req_size);

	// reads count their own last beat while writes trust wlast
	assign last_beat = in_read ? (beat_cnt == req_len) : wlast;
	assign beat_data = in_read ? '0 : wdata_masked;
	assign beat_tag  = {last_beat, req_id};

	assign push_beat = {beat_addr, beat_data, !in_read, beat_tag, req_size};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= beat_pkg::IDLE;
		end else begin
			case (state)
				beat_pkg::IDLE: begin
					if (aw_take)
						state <= beat_pkg::WRITE_BURST;
					else if (ar_take)
						state <= beat_pkg::READ_START;
				end
				beat_pkg::WRITE_BURST: begin
					if (beat_push && wlast)
						state <= beat_pkg::IDLE;
				end
				beat_pkg::READ_START: begin
					if (beat_push)
						state <= last_beat ? beat_pkg::IDLE : beat_pkg::READ_BURST;
				end
				beat_pkg::READ_BURST: begin
					if (beat_push && last_beat)
						state <= beat_pkg::IDLE;
				end
				default: state <= beat_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			beat_cnt <= '0;
		end else if (aw_take || ar_take) begin
			beat_cnt <= '0;
		end else if (beat_push) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (aw_take) begin
			req_id    <= awid;
			req_addr  <= awaddr;
			req_len   <= awlen;
			req_size  <= awsize;
			req_burst <= awburst;
		end else if (ar_take) begin
			req_id    <= arid;
			req_addr  <= araddr;
			req_len   <= arlen;
			req_size  <= arsize;
			req_burst <= arburst;
		end
	end

	// wrap bursts are not supported
	a_no_wrap_aw: assert property (@(posedge aclk) disable iff (!aresetn)
		aw_take |-> awburst != axi_pkg::BURST_WRAP)
		else $error("WRAP write burst accepted");

	a_no_wrap_ar: assert property (@(posedge aclk) disable iff (!aresetn)
		ar_take |-> arburst != axi_pkg::BURST_WRAP)
		else $error("WRAP read burst accepted");

	// no read beat past arlen+1
	a_read_len: assert property (@(posedge aclk) disable iff (!aresetn)
		in_read |-> beat_cnt <= req_len)
		else $error("read burst overran its length");

endmodule

// ==== verilog/beat_queue.sv ====
`timescale 1ns/100ps

module beat_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic            aclk,
	input  logic            aresetn,
	input  logic            beat_push,
	input  beat_pkg::beat_t push_beat,
	input  logic            beat_pop,
	output beat_pkg::beat_t head_beat,
	output logic            queue_full,
	output logic            queue_empty
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	beat_pkg::beat_t  mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	assign queue_full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign queue_empty = (count == '0);

	// head comes straight out of storage
	assign head_beat = mem[rd_ptr];

	always_ff @(posedge aclk) begin
		if (beat_push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	// pointers wrap on their own as the depth is a power of two
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (beat_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (beat_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({beat_push, beat_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
		beat_push |-> !queue_full)
		else $error("push into full beat queue");

	a_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
		beat_pop |-> !queue_empty)
		else $error("pop from empty beat queue");

endmodule

// ==== verilog/fifo_writer.sv ====
`timescale 1ns/100ps

module fifo_writer (
	input  logic            aclk,
	input  logic            aresetn,
	input  beat_pkg::beat_t head_beat,
	input  logic            queue_empty,
	input  logic            addr_fifo_full,
	input  logic            data_fifo_full,
	input  logic            state_fifo_full,
	input  logic            id_send_fifo_full,
	input  logic            size_fifo_full,
	output logic            beat_pop,
	output logic            fifo_w_en,
	output axi_pkg::addr_t  axi_addr,
	output axi_pkg::data_t  axi_data,
	output logic            axi_write,
	output beat_pkg::tag_t  axi_id,
	output axi_pkg::size_t  axi_size
);

	logic            stall;
	axi_pkg::addr_t  head_addr;
	axi_pkg::data_t  head_data;
	logic            head_write;
	beat_pkg::tag_t  head_tag;
	axi_pkg::size_t  head_size;

	// any full fifo holds all five
	assign stall = addr_fifo_full | data_fifo_full | state_fifo_full
		| id_send_fifo_full | size_fifo_full;

	assign beat_pop = !queue_empty && !stall;

	assign {head_addr, head_data, head_write, head_tag, head_size} = head_beat;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			fifo_w_en <= 1'b0;
		else
			fifo_w_en <= beat_pop;
	end

	always_ff @(posedge aclk) begin
		if (beat_pop) begin
			axi_addr  <= head_addr;
			axi_data  <= head_data;
			axi_write <= head_write;
			axi_id    <= head_tag;
			axi_size  <= head_size;
		end
	end

endmodule

// ==== verilog/axi2fifo.sv ====
`timescale 1ns/100ps

module axi2fifo #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic            aclk,
	input  logic            aresetn,
	// aw channel
	input  axi_pkg::id_t    awid,
	input  axi_pkg::addr_t  awaddr,
	input  axi_pkg::len_t   awlen,
	input  axi_pkg::size_t  awsize,
	input  axi_pkg::burst_t awburst,
	input  logic            awvalid,
	output logic            awready,
	// w channel
	input  axi_pkg::data_t  wdata,
	input  axi_pkg::strb_t  wstrb,
	input  logic            wlast,
	input  logic            wvalid,
	output logic            wready,
	// ar channel
	input  axi_pkg::id_t    arid,
	input  axi_pkg::addr_t  araddr,
	input  axi_pkg::len_t   arlen,
	input  axi_pkg::size_t  arsize,
	input  axi_pkg::burst_t arburst,
	input  logic            arvalid,
	output logic            arready,
	// command fifos
	output axi_pkg::addr_t  axi_addr,
	output logic            addr_w_en,
	input  logic            addr_fifo_full,
	output axi_pkg::data_t  axi_data,
	output logic            data_w_en,
	input  logic            data_fifo_full,
	output logic            axi_write,
	output logic            state_w_en,
	input  logic            state_fifo_full,
	output beat_pkg::tag_t  axi_id,
	output logic            id_send_w_en,
	input  logic            id_send_fifo_full,
	output axi_pkg::size_t  axi_size,
	output logic            size_w_en,
	input  logic            size_fifo_full
);

	logic            beat_push;
	beat_pkg::beat_t push_beat;
	logic            queue_full;
	beat_pkg::beat_t head_beat;
	logic            queue_empty;
	logic            beat_pop;
	logic            fifo_w_en;

	burst_sequencer u_seq (
		.aclk(aclk), .aresetn(aresetn),
		.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
		.awburst(awburst), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
		.arburst(arburst), .arvalid(arvalid), .arready(arready),
		.queue_full(queue_full), .beat_push(beat_push), .push_beat(push_beat)
	);

	beat_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.aclk(aclk), .aresetn(aresetn),
		.beat_push(beat_push), .push_beat(push_beat), .beat_pop(beat_pop),
		.head_beat(head_beat), .queue_full(queue_full), .queue_empty(queue_empty)
	);

	fifo_writer u_writer (
		.aclk(aclk), .aresetn(aresetn),
		.head_beat(head_beat), .queue_empty(queue_empty),
		.addr_fifo_full(addr_fifo_full), .data_fifo_full(data_fifo_full),
		.state_fifo_full(state_fifo_full), .id_send_fifo_full(id_send_fifo_full),
		.size_fifo_full(size_fifo_full),
		.beat_pop(beat_pop), .fifo_w_en(fifo_w_en),
		.axi_addr(axi_addr), .axi_data(axi_data), .axi_write(axi_write),
		.axi_id(axi_id), .axi_size(axi_size)
	);

	// one strobe shared by all five fifos
	assign addr_w_en    = fifo_w_en;
	assign data_w_en    = fifo_w_en;
	assign state_w_en   = fifo_w_en;
	assign id_send_w_en = fifo_w_en;
	assign size_w_en    = fifo_w_en;

endmodule

// ==== dv/tb_axi2fifo.sv ====
`timescale 1ns/100ps

module tb_axi2fifo;

	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct packed {
		axi_pkg::addr_t addr;
		axi_pkg::data_t data;
		logic           write;
		beat_pkg::tag_t tag;
		axi_pkg::size_t size;
	} exp_beat_t;

	logic aclk = 1'b0;
	logic aresetn = 1'b0;
	axi_pkg::id_t    awid;
	axi_pkg::addr_t  awaddr;
	axi_pkg::len_t   awlen;
	axi_pkg::size_t  awsize;
	axi_pkg::burst_t awburst;
	logic            awvalid;
	logic            awready;
	axi_pkg::data_t  wdata;
	axi_pkg::strb_t  wstrb;
	logic            wlast;
	logic            wvalid;
	logic            wready;
	axi_pkg::id_t    arid;
	axi_pkg::addr_t  araddr;
	axi_pkg::len_t   arlen;
	axi_pkg::size_t  arsize;
	axi_pkg::burst_t arburst;
	logic            arvalid;
	logic            arready;
	axi_pkg::addr_t  axi_addr;
	axi_pkg::data_t  axi_data;
	logic            axi_write;
	beat_pkg::tag_t  axi_id;
	axi_pkg::size_t  axi_size;
	logic addr_w_en;
	logic data_w_en;
	logic state_w_en;
	logic id_send_w_en;
	logic size_w_en;
	logic addr_fifo_full = 1'b0;
	logic data_fifo_full = 1'b0;
	logic state_fifo_full = 1'b0;
	logic id_send_fifo_full = 1'b0;
	logic size_fifo_full = 1'b0;
	logic any_full;

	exp_beat_t       exp_q[$];
	exp_beat_t       exp = '0;
	logic            exp_ok = 1'b0;
	logic            xfer_seen = 1'b0;
	logic            w_open = 1'b0;
	logic            full_random = 1'b0;
	axi_pkg::id_t    cur_id;
	axi_pkg::addr_t  cur_addr;
	axi_pkg::size_t  cur_size;
	axi_pkg::burst_t cur_burst;
	int beat_idx;
	int beats_in = 0;
	int beats_out = 0;
	int ready_drops = 0;
	int errors = 0;
	int err_base = 0;
	int test_num = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;

	axi2fifo UUT (.*);

	always #20 aclk = ~aclk;

	assign any_full = addr_fifo_full | data_fifo_full | state_fifo_full
		| id_send_fifo_full | size_fifo_full;

	function automatic void value_error(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("ERR %s got %h expected %h", name, got, want);
	endfunction

	function automatic void note_failure(input string msg);
		errors++;
		$display("%s", msg);
	endfunction

	// FIXED stays on the start address and INCR steps one transfer size per beat
	function automatic axi_pkg::addr_t beat_addr(input axi_pkg::addr_t start, input int idx,
		input axi_pkg::size_t size, input axi_pkg::burst_t burst);
		int bytes;
		if (burst == axi_pkg::BURST_FIXED)
			return start;
		bytes = 1 << size;
		return start + axi_pkg::addr_t'(idx * bytes);
	endfunction

	function automatic axi_pkg::data_t strobe_mask(input axi_pkg::strb_t strb);
		axi_pkg::data_t mask;
		for (int i = 0; i < axi_pkg::DATA_W / 8; i++)
			mask[8*i +: 8] = {8{strb[i]}};
		return mask;
	endfunction

	// reference model sampled mid-cycle where every level is settled
	always @(negedge aclk) begin
		if (addr_w_en) begin
			beats_out++;
			exp_ok = (exp_q.size() != 0);
			if (exp_ok)
				exp = exp_q.pop_front();
		end
		if (full_random && UUT.queue_full)
			ready_drops++;
		if (awvalid && awready) begin
			cur_id = awid;
			cur_addr = awaddr;
			cur_size = awsize;
			cur_burst = awburst;
			beat_idx = 0;
			xfer_seen = 1'b1;
			w_open = 1'b1;
		end
		if (wvalid && wready) begin
			exp_q.push_back('{addr: beat_addr(cur_addr, beat_idx, cur_size, cur_burst),
				data: wdata & strobe_mask(wstrb), write: 1'b1,
				tag: {wlast, cur_id}, size: cur_size});
			beat_idx++;
			beats_in++;
			if (wlast)
				w_open = 1'b0;
		end
		if (arvalid && arready) begin
			xfer_seen = 1'b1;
			for (int i = 0; i <= int'(arlen); i++) begin
				exp_q.push_back('{addr: beat_addr(araddr, i, arsize, arburst),
					data: '0, write: 1'b0, tag: {(i == int'(arlen)), arid}, size: arsize});
				beats_in++;
			end
		end
	end

	a_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
		!xfer_seen |-> !addr_w_en)
		else note_failure("write enable before any channel transfer");
	a_strobes: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en == data_w_en && addr_w_en == state_w_en
		&& addr_w_en == id_send_w_en && addr_w_en == size_w_en)
		else note_failure("the five write enables differ");
	a_expected: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en |-> exp_ok)
		else note_failure("write enable with no beat expected");
	a_addr: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en && exp_ok |-> axi_addr == exp.addr)
		else value_error("axi_addr", 64'($sampled(axi_addr)), 64'(exp.addr));
	a_data: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en && exp_ok |-> axi_data == exp.data)
		else value_error("axi_data", $sampled(axi_data), exp.data);
	a_write: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en && exp_ok |-> axi_write == exp.write)
		else value_error("axi_write", 64'($sampled(axi_write)), 64'(exp.write));
	a_id: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en && exp_ok |-> axi_id == exp.tag)
		else value_error("axi_id", 64'($sampled(axi_id)), 64'(exp.tag));
	a_size: assert property (@(posedge aclk) disable iff (!aresetn)
		addr_w_en && exp_ok |-> axi_size == exp.size)
		else value_error("axi_size", 64'($sampled(axi_size)), 64'(exp.size));
	a_stall: assert property (@(posedge aclk) disable iff (!aresetn)
		any_full |=> !addr_w_en)
		else note_failure("write enable in the cycle after a full input");
	a_ready_drop: assert property (@(posedge aclk) disable iff (!aresetn)
		UUT.queue_full |-> !awready && !wready && !arready)
		else note_failure("ready high while the beat queue is full");
	a_write_first: assert property (@(posedge aclk) disable iff (!aresetn)
		(awvalid || w_open) |-> !arready)
		else note_failure("read accepted while a write was pending");

	// each full input high about a quarter of the time
	always @(posedge aclk) begin
		#2;
		if (full_random)
			{addr_fifo_full, data_fifo_full, state_fifo_full, id_send_fifo_full,
				size_fifo_full} = 5'($urandom) & 5'($urandom);
		else
			{addr_fifo_full, data_fifo_full, state_fifo_full, id_send_fifo_full,
				size_fifo_full} = '0;
	end

	task automatic send_write(input axi_pkg::id_t id, input axi_pkg::addr_t addr,
		input axi_pkg::len_t len, input axi_pkg::size_t size, input axi_pkg::burst_t burst);
		{awid, awaddr, awlen, awsize, awburst} = {id, addr, len, size, burst};
		awvalid = 1'b1;
		@(negedge aclk);
		while (!awready)
			@(negedge aclk);
		@(posedge aclk);
		#2;
		awvalid = 1'b0;
		for (int i = 0; i <= int'(len); i++) begin
			wdata = {$urandom, $urandom};
			wstrb = axi_pkg::strb_t'($urandom);
			wlast = (i == int'(len));
			wvalid = 1'b1;
			@(negedge aclk);
			while (!wready)
				@(negedge aclk);
			@(posedge aclk);
			#2;
		end
		wvalid = 1'b0;
		wlast = 1'b0;
	endtask

	task automatic send_read(input axi_pkg::id_t id, input axi_pkg::addr_t addr,
		input axi_pkg::len_t len, input axi_pkg::size_t size, input axi_pkg::burst_t burst);
		{arid, araddr, arlen, arsize, arburst} = {id, addr, len, size, burst};
		arvalid = 1'b1;
		@(negedge aclk);
		while (!arready)
			@(negedge aclk);
		@(posedge aclk);
		#2;
		arvalid = 1'b0;
	endtask

	// drain the expected beats, then report the test
	task automatic finish_test(input string name);
		int test_errors;
		while (exp_q.size() != 0)
			@(posedge aclk);
		repeat (4) @(posedge aclk);
		#2;
		assert (beats_out == beats_in)
			else note_failure($sformatf("%s: %0d beats in, %0d beats out", name,
				beats_in, beats_out));
		test_errors = errors - err_base;
		err_base = errors;
		test_num++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(test_errors == 0) ? "pass" : "fail", test_errors);
	endtask

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge aclk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles", cycle_cnt);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(41528));
		{awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
		{wdata, wstrb, wlast, wvalid} = '0;
		{arid, araddr, arlen, arsize, arburst, arvalid} = '0;
		repeat (8) @(posedge aclk);
		#2;
		aresetn = 1'b1;
		@(posedge aclk);
		#2;

		assert (awready && !wready && !arready)
			else note_failure("ready levels wrong after reset");
		repeat (6) @(posedge aclk);
		#2;
		finish_test("idle after reset");

		send_write(axi_pkg::id_t'($urandom), 32'h1000_0040, 8'd3, 3'd3, axi_pkg::BURST_INCR);
		finish_test("incr write");

		send_read(axi_pkg::id_t'($urandom), 32'h2000_0100, 8'd5, 3'd2, axi_pkg::BURST_INCR);
		finish_test("incr read");

		send_write(axi_pkg::id_t'($urandom), 32'h3000_0010, 8'd2, 3'd3, axi_pkg::BURST_FIXED);
		send_read(axi_pkg::id_t'($urandom), 32'h3000_0020, 8'd3, 3'd3, axi_pkg::BURST_FIXED);
		finish_test("fixed write and read");

		fork
			send_write(8'h11, 32'h4000_0000, 8'd4, 3'd3, axi_pkg::BURST_INCR);
			send_read(8'h22, 32'h5000_0000, 8'd2, 3'd1, axi_pkg::BURST_INCR);
		join
		finish_test("write before read");

		full_random = 1'b1;
		fork
			send_write(8'h33, 32'h6000_0000, 8'd15, 3'd3, axi_pkg::BURST_INCR);
			send_read(8'h44, 32'h7000_0000, 8'd11, 3'd2, axi_pkg::BURST_INCR);
		join
		full_random = 1'b0;
		assert (ready_drops > 0)
			else note_failure("beat queue never filled under back-pressure");
		finish_test("random back-pressure");

		$display("%0d tests passed, %0d failed, %0d errors", test_num - tests_failed,
			tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== all.f ====
verilog/axi_pkg.sv
verilog/beat_pkg.sv
verilog/burst_sequencer.sv
verilog/beat_queue.sv
verilog/fifo_writer.sv
verilog/axi2fifo.sv
dv/tb_axi2fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f all.f --top-module tb_axi2fifo \
	&& ./obj_dir/Vtb_axi2fifo > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
